// ==== logic/dbsao_pkg.sv ====
//**************************************************************************
// deblocking / sao engine package
// sample, qp and motion vector types, state encoding, filter and band
// constants shared by every stage of the edge engine
//**************************************************************************
package dbsao_pkg;

  localparam int PIXEL_WIDTH   = 8;
  localparam int SIDE_PIXELS   = 4;   // samples on each side of the edge
  localparam int QP_WIDTH      = 6;
  localparam int FMV_WIDTH     = 10;  // quarter-pel units
  localparam int MV_BS_THRESH  = 4;   // one integer pixel
  localparam int TC_SHIFT      = 3;
  localparam int BAND_SHIFT    = 3;   // 32 bands over 8-bit samples
  localparam int SAO_BANDS     = 4;
  localparam int SAO_OFS_WIDTH = 4;

  typedef logic [PIXEL_WIDTH-1:0]            pixel_t;
  typedef pixel_t [SIDE_PIXELS-1:0]          side_t;        // [0] sits next to the edge
  typedef logic signed [PIXEL_WIDTH+5:0]     sample_ext_t;  // headroom for filter math
  typedef logic [PIXEL_WIDTH-BAND_SHIFT-1:0] band_t;

  typedef struct packed {
    logic signed [FMV_WIDTH-1:0] x;
    logic signed [FMV_WIDTH-1:0] y;
  } mv_t;

  typedef logic [1:0]                       bs_t;
  typedef logic [QP_WIDTH-1:0]              qp_t;
  typedef logic signed [SAO_OFS_WIDTH-1:0]  sao_ofs_val_t;
  typedef sao_ofs_val_t [SAO_BANDS-1:0]     sao_ofs_t;

  typedef enum logic [2:0] {
    IDLE = 3'b000,
    LOAD = 3'b001,
    DBY  = 3'b011,
    SAO  = 3'b100,
    OUT  = 3'b101
  } dbsao_state_e;

  function automatic sample_ext_t ext_pixel(input pixel_t v);
    return sample_ext_t'(v);  // zero extended, then signed
  endfunction

  // saturate back into the sample range
  function automatic pixel_t clip_pixel(input sample_ext_t v);
    if (v < 0)
      return '0;
    if (v > (2**PIXEL_WIDTH - 1))
      return '1;
    return v[PIXEL_WIDTH-1:0];
  endfunction

endpackage

// ==== logic/dbsao_edge_if.sv ====
//**************************************************************************
// edge job interface
// latched job and stage state from the controller to the three stages
//**************************************************************************
`timescale 1ns/1ns

interface dbsao_edge_if (
  input logic clk
);
  import dbsao_pkg::*;

  dbsao_state_e state;
  side_t        p_pxl;
  side_t        q_pxl;
  qp_t          qp_p;
  qp_t          qp_q;
  logic         intra;
  logic         tu_edge;
  logic         pu_edge;
  logic         cbf_p;
  logic         cbf_q;
  mv_t          mv_p;
  mv_t          mv_q;
  logic         db_ena;
  logic         sao_ena;
  band_t        band_pos;
  sao_ofs_t     band_ofs;

  modport ctrl (
    input  clk,
    output state, p_pxl, q_pxl, qp_p, qp_q, intra, tu_edge, pu_edge,
           cbf_p, cbf_q, mv_p, mv_q, db_ena, sao_ena, band_pos, band_ofs
  );

  modport bs   (input clk, state, qp_p, qp_q, intra, tu_edge, pu_edge,
                cbf_p, cbf_q, mv_p, mv_q);
  modport filt (input clk, state, p_pxl, q_pxl, db_ena);
  modport sao  (input clk, state, sao_ena, band_pos, band_ofs);

endinterface

// ==== logic/dbsao_controller.sv ====
//**************************************************************************
// dbsao controller
// sequences one edge job through load, deblock and sao with a four-phase
// req/ack handshake and holds the job register for the stages
//**************************************************************************
`timescale 1ns/1ns

module dbsao_controller (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  dbsao_pkg::side_t      p_pxl_i,
  input  dbsao_pkg::side_t      q_pxl_i,
  input  dbsao_pkg::qp_t        qp_p_i,
  input  dbsao_pkg::qp_t        qp_q_i,
  input  logic                  intra_i,
  input  logic                  tu_edge_i,
  input  logic                  pu_edge_i,
  input  logic                  cbf_p_i,
  input  logic                  cbf_q_i,
  input  dbsao_pkg::mv_t        mv_p_i,
  input  dbsao_pkg::mv_t        mv_q_i,
  input  logic                  db_ena_i,
  input  logic                  sao_ena_i,
  input  dbsao_pkg::band_t      sao_band_pos_i,
  input  dbsao_pkg::sao_ofs_t   sao_offset_i,
  output logic                  ack_o,
  dbsao_edge_if.ctrl            edge_o
);
  import dbsao_pkg::*;

  dbsao_state_e state_q;
  dbsao_state_e state_d;

  //**************************************************************************
  // state sequence
  //**************************************************************************
  always_comb begin
    case (state_q)
      IDLE:    state_d = req_i ? LOAD : IDLE;
      LOAD:    state_d = DBY;
      DBY:     state_d = SAO;
      SAO:     state_d = OUT;
      OUT:     state_d = req_i ? OUT : IDLE;  // hold ack until req drops
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // job register, captured when leaving idle
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      edge_o.p_pxl    <= p_pxl_i;
      edge_o.q_pxl    <= q_pxl_i;
      edge_o.qp_p     <= qp_p_i;
      edge_o.qp_q     <= qp_q_i;
      edge_o.intra    <= intra_i;
      edge_o.tu_edge  <= tu_edge_i;
      edge_o.pu_edge  <= pu_edge_i;
      edge_o.cbf_p    <= cbf_p_i;
      edge_o.cbf_q    <= cbf_q_i;
      edge_o.mv_p     <= mv_p_i;
      edge_o.mv_q     <= mv_q_i;
      edge_o.db_ena   <= db_ena_i;
      edge_o.sao_ena  <= sao_ena_i;
      edge_o.band_pos <= sao_band_pos_i;
      edge_o.band_ofs <= sao_offset_i;
    end
  end

  assign edge_o.state = state_q;
  assign ack_o        = (state_q == OUT);

endmodule

// ==== logic/db_bs.sv ====
//**************************************************************************
// boundary strength
// derives bs, tc and beta from the edge attributes once per job
//**************************************************************************
`timescale 1ns/1ns

module db_bs (
  input  logic            clk,
  input  logic            rst_n_i,
  dbsao_edge_if.bs        edge_i,
  output dbsao_pkg::bs_t  bs_o,
  output dbsao_pkg::qp_t  tc_o,
  output dbsao_pkg::qp_t  beta_o
);
  import dbsao_pkg::*;

  logic signed [FMV_WIDTH:0] mv_dx;   // one extra bit for the difference
  logic signed [FMV_WIDTH:0] mv_dy;
  logic        [FMV_WIDTH:0] mv_ax;
  logic        [FMV_WIDTH:0] mv_ay;
  logic                      mv_big;
  logic        [QP_WIDTH:0]  qp_sum;
  qp_t                       qp_avg;
  bs_t                       bs_d;

  always_comb begin
    mv_dx  = edge_i.mv_p.x - edge_i.mv_q.x;
    mv_dy  = edge_i.mv_p.y - edge_i.mv_q.y;
    mv_ax  = (mv_dx < 0) ? -mv_dx : mv_dx;
    mv_ay  = (mv_dy < 0) ? -mv_dy : mv_dy;
    mv_big = (mv_ax >= MV_BS_THRESH) || (mv_ay >= MV_BS_THRESH);

    // first matching rule wins
    if (edge_i.intra && (edge_i.tu_edge || edge_i.pu_edge))
      bs_d = 2'd2;
    else if (edge_i.tu_edge && (edge_i.cbf_p || edge_i.cbf_q))
      bs_d = 2'd1;
    else if (edge_i.pu_edge && mv_big)
      bs_d = 2'd1;
    else
      bs_d = 2'd0;

    qp_sum = edge_i.qp_p + edge_i.qp_q + 1'b1;
    qp_avg = qp_sum[QP_WIDTH:1];  // rounded mean
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bs_o   <= '0;
      tc_o   <= '0;
      beta_o <= '0;
    end else if (edge_i.state == LOAD) begin
      bs_o   <= bs_d;
      tc_o   <= (qp_avg >> TC_SHIFT) + bs_d;
      beta_o <= qp_avg;
    end
  end

endmodule

// ==== logic/db_filter.sv ====
//**************************************************************************
// weak luma deblocking filter
// on/off decision from the second differences, then p0/q0 correction
//**************************************************************************
`timescale 1ns/1ns

module db_filter (
  input  logic              clk,
  input  logic              rst_n_i,
  dbsao_edge_if.filt        edge_i,
  input  dbsao_pkg::bs_t    bs_i,
  input  dbsao_pkg::qp_t    tc_i,
  input  dbsao_pkg::qp_t    beta_i,
  output dbsao_pkg::side_t  p_o,
  output dbsao_pkg::side_t  q_o
);
  import dbsao_pkg::*;

  // |s2 - 2*s1 + s0| on one side of the edge
  function automatic sample_ext_t second_diff(input side_t s);
    sample_ext_t v;
    v = ext_pixel(s[2]) - 2 * ext_pixel(s[1]) + ext_pixel(s[0]);
    return (v < 0) ? -v : v;
  endfunction

  sample_ext_t p0;
  sample_ext_t p1;
  sample_ext_t q0;
  sample_ext_t q1;
  sample_ext_t d;
  sample_ext_t tc_s;
  sample_ext_t delta_raw;
  sample_ext_t delta_abs;
  sample_ext_t delta;
  logic        filt_on;
  side_t       p_d;
  side_t       q_d;

  //**************************************************************************
  // decision and delta
  //**************************************************************************
  always_comb begin
    p0   = ext_pixel(edge_i.p_pxl[0]);
    p1   = ext_pixel(edge_i.p_pxl[1]);
    q0   = ext_pixel(edge_i.q_pxl[0]);
    q1   = ext_pixel(edge_i.q_pxl[1]);
    tc_s = sample_ext_t'(tc_i);
    d    = second_diff(edge_i.p_pxl) + second_diff(edge_i.q_pxl);

    delta_raw = (9 * (q0 - p0) - 3 * (q1 - p1) + 8) >>> 4;
    delta_abs = (delta_raw < 0) ? -delta_raw : delta_raw;
    delta     = (delta_raw > tc_s)  ? tc_s :
                (delta_raw < -tc_s) ? -tc_s : delta_raw;  // clip to +-tc

    // large steps are treated as real edges and left alone
    filt_on = edge_i.db_ena && (bs_i != '0) &&
              (d < sample_ext_t'(beta_i)) && (delta_abs < 10 * tc_s);

    p_d = edge_i.p_pxl;
    q_d = edge_i.q_pxl;
    if (filt_on) begin
      p_d[0] = clip_pixel(p0 + delta);
      q_d[0] = clip_pixel(q0 - delta);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      p_o <= '0;
      q_o <= '0;
    end else if (edge_i.state == DBY) begin
      p_o <= p_d;
      q_o <= q_d;
    end
  end

endmodule

// ==== logic/sao_bo.sv ====
//**************************************************************************
// sao band offset
// adds one of four offsets to samples in the selected bands, with clip
//**************************************************************************
`timescale 1ns/1ns

module sao_bo (
  input  logic                   clk,
  input  logic                   rst_n_i,
  dbsao_edge_if.sao              edge_i,
  input  dbsao_pkg::side_t       p_i,
  input  dbsao_pkg::side_t       q_i,
  output dbsao_pkg::side_t [0:1] pxl_o
);
  import dbsao_pkg::*;

  side_t [0:1] line_in;   // [0] p side, [1] q side
  side_t [0:1] line_d;
  band_t       band;
  band_t       rel;       // band relative to band_pos, no wrap
  sample_ext_t ofs;

  always_comb begin
    line_in[0] = p_i;
    line_in[1] = q_i;
    line_d     = line_in;
    band       = '0;
    rel        = '0;
    ofs        = '0;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < SIDE_PIXELS; k++) begin
        band = line_in[s][k][PIXEL_WIDTH-1:BAND_SHIFT];
        rel  = band - edge_i.band_pos;
        ofs  = sample_ext_t'(edge_i.band_ofs[rel[$clog2(SAO_BANDS)-1:0]]);
        if (edge_i.sao_ena && band >= edge_i.band_pos && rel < SAO_BANDS)
          line_d[s][k] = clip_pixel(ext_pixel(line_in[s][k]) + ofs);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      pxl_o <= '0;
    else if (edge_i.state == SAO)
      pxl_o <= line_d;
  end

endmodule

// ==== logic/dbsao_top.sv ====
//**************************************************************************
// dbsao top
// single-edge luma deblocking and sao band offset engine
//**************************************************************************
`timescale 1ns/1ns

module dbsao_top (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  dbsao_pkg::side_t        p_pxl_i,
  input  dbsao_pkg::side_t        q_pxl_i,
  input  dbsao_pkg::qp_t          qp_p_i,
  input  dbsao_pkg::qp_t          qp_q_i,
  input  logic                    intra_i,
  input  logic                    tu_edge_i,
  input  logic                    pu_edge_i,
  input  logic                    cbf_p_i,
  input  logic                    cbf_q_i,
  input  dbsao_pkg::mv_t          mv_p_i,
  input  dbsao_pkg::mv_t          mv_q_i,
  input  logic                    db_ena_i,
  input  logic                    sao_ena_i,
  input  dbsao_pkg::band_t        sao_band_pos_i,
  input  dbsao_pkg::sao_ofs_t     sao_offset_i,
  output logic                    ack_o,
  output dbsao_pkg::side_t [0:1]  pxl_o,    // p side, then q side
  output dbsao_pkg::bs_t          bs_o
);
  import dbsao_pkg::*;

  qp_t   tc_w;
  qp_t   beta_w;
  side_t p_filt_w;
  side_t q_filt_w;

  dbsao_edge_if u_edge_if (.clk(clk));

  dbsao_controller u_controller (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .p_pxl_i        (p_pxl_i),
    .q_pxl_i        (q_pxl_i),
    .qp_p_i         (qp_p_i),
    .qp_q_i         (qp_q_i),
    .intra_i        (intra_i),
    .tu_edge_i      (tu_edge_i),
    .pu_edge_i      (pu_edge_i),
    .cbf_p_i        (cbf_p_i),
    .cbf_q_i        (cbf_q_i),
    .mv_p_i         (mv_p_i),
    .mv_q_i         (mv_q_i),
    .db_ena_i       (db_ena_i),
    .sao_ena_i      (sao_ena_i),
    .sao_band_pos_i (sao_band_pos_i),
    .sao_offset_i   (sao_offset_i),
    .ack_o          (ack_o),
    .edge_o         (u_edge_if.ctrl)
  );

  db_bs u_db_bs (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .edge_i  (u_edge_if.bs),
    .bs_o    (bs_o),      // also feeds the filter decision
    .tc_o    (tc_w),
    .beta_o  (beta_w)
  );

  db_filter u_db_filter (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .edge_i  (u_edge_if.filt),
    .bs_i    (bs_o),
    .tc_i    (tc_w),
    .beta_i  (beta_w),
    .p_o     (p_filt_w),
    .q_o     (q_filt_w)
  );

  sao_bo u_sao_bo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .edge_i  (u_edge_if.sao),
    .p_i     (p_filt_w),
    .q_i     (q_filt_w),
    .pxl_o   (pxl_o)
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
//**************************************************************************
// testbench clock generator
// free-running clock with a fixed period
//**************************************************************************
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// ==== verification/dbsao_tb.sv ====
//**************************************************************************
// dbsao testbench
// directed and random edge jobs through the four-phase handshake, checked
// against a reference model of bs, weak filter and sao band offset
//**************************************************************************
`timescale 1ns/1ns

module dbsao_tb;
  import dbsao_pkg::*;

  localparam int          RESET_CYCLES  = 8;
  localparam int          DIRECTED_JOBS = 13;
  localparam int          RANDOM_JOBS   = 200;
  localparam int          ACK_EDGES     = 4;  // counting the edge that samples req_i
  localparam int          CYCLE_LIMIT   = (DIRECTED_JOBS + RANDOM_JOBS) * 12 + RESET_CYCLES;
  localparam int unsigned RAND_SEED     = 32'h5490_67e8;

  typedef struct packed {
    side_t    p;
    side_t    q;
    qp_t      qp_p;
    qp_t      qp_q;
    logic     intra, tu_edge, pu_edge, cbf_p, cbf_q;
    mv_t      mv_p;
    mv_t      mv_q;
    logic     db_ena;
    logic     sao_ena;
    band_t    band_pos;
    sao_ofs_t sao_ofs;
  } job_t;

  typedef struct packed {
    bs_t         bs;
    side_t [0:1] pxl;
  } expect_t;

  logic        clk;
  logic        rst_n_i;
  logic        req_i;
  job_t        cur_job;
  logic        ack_o;
  side_t [0:1] pxl_o;
  bs_t         bs_o;
  expect_t     exp_q[$];  // one entry per job in flight
  int          data_errors  = 0;
  int          proto_errors = 0;
  int          checks       = 0;
  int          cycles;

  tb_clk_gen #(.PERIOD_NS(8)) u_clk_gen (.clk_o(clk));

  dbsao_top dbsao_top_i (
    .clk(clk), .rst_n_i(rst_n_i), .req_i(req_i),
    .p_pxl_i(cur_job.p), .q_pxl_i(cur_job.q), .qp_p_i(cur_job.qp_p), .qp_q_i(cur_job.qp_q),
    .intra_i(cur_job.intra), .tu_edge_i(cur_job.tu_edge), .pu_edge_i(cur_job.pu_edge),
    .cbf_p_i(cur_job.cbf_p), .cbf_q_i(cur_job.cbf_q),
    .mv_p_i(cur_job.mv_p), .mv_q_i(cur_job.mv_q),
    .db_ena_i(cur_job.db_ena), .sao_ena_i(cur_job.sao_ena),
    .sao_band_pos_i(cur_job.band_pos), .sao_offset_i(cur_job.sao_ofs),
    .ack_o(ack_o), .pxl_o(pxl_o), .bs_o(bs_o)
  );

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  function automatic pixel_t clamp_sample(input int v);
    if (v < 0)
      return 8'd0;
    if (v > 255)
      return 8'd255;
    return pixel_t'(v);
  endfunction

  //**************************************************************************
  // reference model
  //**************************************************************************
  function automatic expect_t expected_result(input job_t j);
    expect_t r;
    int      px [8];  // p0..p3 then q0..q3
    int      mdx;
    int      mdy;
    int      qp_avg;
    int      tc;
    int      d;
    int      delta;
    int      rel;
    for (int k = 0; k < SIDE_PIXELS; k++) begin
      px[k]     = j.p[k];
      px[4 + k] = j.q[k];
    end
    mdx = $signed(j.mv_p.x) - $signed(j.mv_q.x);
    mdy = $signed(j.mv_p.y) - $signed(j.mv_q.y);
    if (j.intra && (j.tu_edge || j.pu_edge))
      r.bs = 2'd2;
    else if (j.tu_edge && (j.cbf_p || j.cbf_q))
      r.bs = 2'd1;
    else if (j.pu_edge && (abs_int(mdx) >= MV_BS_THRESH || abs_int(mdy) >= MV_BS_THRESH))
      r.bs = 2'd1;
    else
      r.bs = 2'd0;
    qp_avg = (int'(j.qp_p) + int'(j.qp_q) + 1) / 2;  // also beta
    tc     = (qp_avg >> TC_SHIFT) + int'(r.bs);
    d      = abs_int(px[2] - 2 * px[1] + px[0]) + abs_int(px[6] - 2 * px[5] + px[4]);
    delta  = (9 * (px[4] - px[0]) - 3 * (px[5] - px[1]) + 8) >>> 4;
    if (j.db_ena && r.bs != 0 && d < qp_avg && abs_int(delta) < 10 * tc) begin
      if (delta > tc)
        delta = tc;
      else if (delta < -tc)
        delta = -tc;
      px[0] = clamp_sample(px[0] + delta);
      px[4] = clamp_sample(px[4] - delta);
    end
    for (int k = 0; k < 8; k++) begin
      rel = (px[k] >> BAND_SHIFT) - int'(j.band_pos);  // no wrap past band 31
      if (j.sao_ena && rel >= 0 && rel < SAO_BANDS)
        px[k] = clamp_sample(px[k] + $signed(j.sao_ofs[rel]));
    end
    for (int k = 0; k < SIDE_PIXELS; k++) begin
      r.pxl[0][k] = pixel_t'(px[k]);
      r.pxl[1][k] = pixel_t'(px[4 + k]);
    end
    return r;
  endfunction

  // flat sides, attr is {intra, tu_edge, pu_edge, cbf_p, cbf_q}
  function automatic job_t edge_job(input int pv, input int qv, input logic [4:0] attr,
                                    input int mv_dx, input int qp);
    job_t j;
    j        = '0;
    j.p      = {SIDE_PIXELS{pixel_t'(pv)}};
    j.q      = {SIDE_PIXELS{pixel_t'(qv)}};
    j.qp_p   = qp_t'(qp);
    j.qp_q   = qp_t'(qp);
    {j.intra, j.tu_edge, j.pu_edge, j.cbf_p, j.cbf_q} = attr;
    j.mv_p.x = FMV_WIDTH'(mv_dx);
    j.db_ena = 1'b1;
    return j;
  endfunction

  function automatic job_t random_job();
    job_t         j;
    logic [159:0] r;
    int           base;
    int           step;
    r        = {$urandom, $urandom, $urandom, $urandom, $urandom};
    j        = r[$bits(job_t)-1:0];
    j.mv_q.x = j.mv_p.x + FMV_WIDTH'(int'($urandom_range(0, 10)) - 5);  // near threshold
    j.mv_q.y = j.mv_p.y + FMV_WIDTH'(int'($urandom_range(0, 10)) - 5);
    if (r[159]) begin  // smooth line so the filter decision can pass
      base = $urandom_range(8, 247);
      step = int'($urandom_range(0, 40)) - 20;
      for (int k = 0; k < SIDE_PIXELS; k++) begin
        j.p[k] = clamp_sample(base + int'($urandom_range(0, 4)) - 2);
        j.q[k] = clamp_sample(base + step + int'($urandom_range(0, 4)) - 2);
      end
    end
    return j;
  endfunction

  //**************************************************************************
  // driver and handshake timing
  //**************************************************************************
  task automatic run_job(input job_t j, input int hold);
    int      edges;
    expect_t held;
    @(posedge clk);
    #1;
    cur_job = j;
    req_i   = 1'b1;
    exp_q.push_back(expected_result(j));
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack_o && edges < 3 * ACK_EDGES);
    assert (ack_o) else begin
      proto_errors++;
      $display("ack_o never rose for the job started before %0t ns", $time);
    end
    assert (edges == ACK_EDGES) else begin
      proto_errors++;
      $display("[FAIL] %0t ns: ack_o after %0d edges, expected %0d", $time, edges, ACK_EDGES);
    end
    held.bs  = bs_o;
    held.pxl = pxl_o;
    repeat (hold) begin
      @(posedge clk);
      #1;
      assert (ack_o && bs_o == held.bs && pxl_o == held.pxl) else begin
        proto_errors++;
        $display("[FAIL] %0t ns: ack_o or outputs changed while req_i held high", $time);
      end
    end
    req_i = 1'b0;
    @(posedge clk);
    #1;
    assert (!ack_o) else begin
      proto_errors++;
      $display("[FAIL] %0t ns: ack_o still high one edge after req_i dropped", $time);
    end
  endtask

  // compares once per ack, sampled away from the driving edge
  initial begin
    logic    ack_seen;
    expect_t e;
    ack_seen = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (ack_o && !ack_seen) begin
        assert (exp_q.size() != 0) else begin
          proto_errors++;
          $display("ack_o rose at %0t ns with no job outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          checks++;
          assert (bs_o == e.bs) else begin
            data_errors++;
            $display("[FAIL] %0t ns: bs_o is %0d, expected %0d", $time, bs_o, e.bs);
          end
          assert (pxl_o == e.pxl) else begin
            data_errors++;
            $display("[FAIL] %0t ns: pxl_o is %h, expected %h", $time, pxl_o, e.pxl);
          end
        end
      end
      ack_seen = ack_o;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("Regression failed");
    $finish;
  end

  //**************************************************************************
  // test sequence
  //**************************************************************************
  initial begin
    job_t j;
    void'($urandom(RAND_SEED));
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    cur_job   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    assert (!ack_o && pxl_o == '0 && bs_o == '0) else begin
      proto_errors++;
      $display("[FAIL] %0t ns: outputs not idle after reset", $time);
    end

    run_job(edge_job(100, 100, 5'b11000, 0, 30), 0);  // intra tu -> 2
    run_job(edge_job(100, 100, 5'b10100, 0, 30), 0);  // intra pu -> 2
    run_job(edge_job(100, 100, 5'b01010, 0, 30), 0);  // tu with cbf -> 1
    run_job(edge_job(100, 100, 5'b00100, 4, 30), 0);  // mv diff 4 -> 1
    run_job(edge_job(100, 100, 5'b00100, 3, 30), 0);  // mv diff 3 -> 0

    run_job(edge_job(60, 76, 5'b11000, 0, 16), 0);   // delta 6 clipped to tc 4
    run_job(edge_job(96, 80, 5'b11000, 0, 16), 0);   // delta -6 clipped to -4
    run_job(edge_job(20, 200, 5'b11000, 0, 16), 0);  // real edge, left alone
    j        = edge_job(60, 70, 5'b11000, 0, 16);
    j.db_ena = 1'b0;
    run_job(j, 0);

    // low clip at band 0, q3 outside the bands
    j          = edge_job(0, 0, 5'b00000, 0, 30);
    j.p        = {8'd40, 8'd20, 8'd9, 8'd2};
    j.q        = {8'd100, 8'd30, 8'd17, 8'd8};
    j.sao_ena  = 1'b1;
    j.band_pos = 5'd0;
    j.sao_ofs  = {4'h2, 4'hd, 4'h5, 4'h8};  // +2 -3 +5 -8
    run_job(j, 0);
    j          = edge_job(0, 0, 5'b00000, 0, 30);
    j.p        = {8'd100, 8'd224, 8'd230, 8'd250};
    j.q        = {8'd255, 8'd245, 8'd239, 8'd216};
    j.sao_ena  = 1'b1;
    j.band_pos = 5'd28;
    j.sao_ofs  = {4'h7, 4'h9, 4'h3, 4'h6};  // +7 -7 +3 +6, high clip
    run_job(j, 0);
    j.sao_ena = 1'b0;
    run_job(j, 0);

    run_job(edge_job(60, 70, 5'b11000, 0, 16), 5);  // back-pressure

    repeat (RANDOM_JOBS) run_job(random_job(), $urandom_range(0, 2));

    assert (exp_q.size() == 0) else begin
      proto_errors++;
      $display("%0d jobs finished without an ack being compared", exp_q.size());
    end
    $display("summary: %0d jobs compared, %0d data errors, %0d protocol errors",
             checks, data_errors, proto_errors);
    if (data_errors + proto_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== files.f ====
logic/dbsao_pkg.sv
logic/dbsao_edge_if.sv
logic/dbsao_controller.sv
logic/db_bs.sv
logic/db_filter.sv
logic/sao_bo.sv
logic/dbsao_top.sv
verification/tb_clk_gen.sv
verification/dbsao_tb.sv

// ==== Bender.yml ====
package:
  name: dbsao

sources:
  - files:
      - logic/dbsao_pkg.sv
      - logic/dbsao_edge_if.sv
      - logic/dbsao_controller.sv
      - logic/db_bs.sv
      - logic/db_filter.sv
      - logic/sao_bo.sv
      - logic/dbsao_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/dbsao_tb.sv
